// ==== list.f ====
noc_pkg.sv
noc_link_if.sv
noc_fifo.sv
noc_router.sv
noc_link_tieoff.sv
noc_mesh.sv
noc_inject.sv
noc_eject.sv
noc_top.sv
tb_noc_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_noc_top
RTL_TOP    := noc_top
FILELIST   := list.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_noc_top.sv ====
`timescale 1ns/100ps
// ********************
// testbench for noc_top as a 3 x 2 mesh
// expected data is kept per destination tile and checked on every output
// with these widths X = 3 is the only address outside the grid
// ********************

module tb_noc_top
  import noc_pkg::*;
();

  localparam int num_x_c  = 3;
  localparam int num_y_c  = 2;
  localparam int tiles_c  = num_x_c * num_y_c;
  localparam int n_rand_c = 200;

  logic                      clk = 1'b0;
  logic                      arst_n_i;
  logic                      in_valid_i;
  logic                      in_ready_o;
  logic [x_cord_width_c-1:0] in_x_i;
  logic [y_cord_width_c-1:0] in_y_i;
  logic [15:0]               in_data_i;
  logic                      out_valid_o;
  logic                      out_ready_i;
  logic [x_cord_width_c-1:0] out_x_o;
  logic [y_cord_width_c-1:0] out_y_o;
  logic [15:0]               out_data_o;
  logic                      misroute_o;

  logic [15:0] exp_q [tiles_c][$]; // expected data per destination tile
  int          errors = 0;
  int          timeouts = 0;
  int          bad_sent = 0;        // packets addressed outside the grid
  int          tests_run = 0;
  int          tests_failed = 0;
  bit          bp_en = 1'b0;

  always #5 clk = ~clk;

  noc_top #(
    .num_x_p(num_x_c)
    ,.num_y_p(num_y_c)
    ,.data_width_p(16)
  ) DUT (
    .clk(clk)
    ,.arst_n_i(arst_n_i)
    ,.in_valid_i(in_valid_i)
    ,.in_ready_o(in_ready_o)
    ,.in_x_i(in_x_i)
    ,.in_y_i(in_y_i)
    ,.in_data_i(in_data_i)
    ,.out_valid_o(out_valid_o)
    ,.out_ready_i(out_ready_i)
    ,.out_x_o(out_x_o)
    ,.out_y_o(out_y_o)
    ,.out_data_o(out_data_o)
    ,.misroute_o(misroute_o)
  );

  // a stalled output keeps its packet
  assert property (@(posedge clk) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
      && $stable(out_x_o) && $stable(out_y_o))
  else begin
    $display("Mismatch at %0t: output changed while out_ready_i was low", $time);
    errors++;
  end

  assert property (@(posedge clk) disable iff (!arst_n_i) misroute_o |=> misroute_o)
  else begin
    $display("Mismatch at %0t: misroute_o dropped without reset", $time);
    errors++;
  end

  assert property (@(posedge clk) disable iff (!arst_n_i) (bad_sent == 0) |-> !misroute_o)
  else begin
    $display("Mismatch at %0t: misroute_o high with only in-range traffic", $time);
    errors++;
  end

  always @(posedge clk) begin
    if (bp_en)
      out_ready_i <= 1'($urandom_range(0, 1));
    else
      out_ready_i <= 1'b1;
  end

  // values at the falling edge are the ones the next rising edge samples
  always @(negedge clk) begin
    int t;
    bit ok;
    if (arst_n_i && in_valid_i && in_ready_o) begin
      if (int'(in_x_i) < num_x_c)
        exp_q[int'(in_y_i) * num_x_c + int'(in_x_i)].push_back(in_data_i);
      else
        bad_sent++;
    end
    if (arst_n_i && out_valid_o && out_ready_i) begin
      t  = int'(out_y_o) * num_x_c + int'(out_x_o);
      ok = (int'(out_x_o) < num_x_c) && (int'(out_y_o) < num_y_c);
      if (ok)
        ok = (exp_q[t].size() != 0);
      assert (ok) else begin
        $display("Mismatch at %0t: unexpected packet %h at tile (%0d,%0d)",
                 $time, out_data_o, out_x_o, out_y_o);
        errors++;
      end
      if (ok) begin
        assert (out_data_o == exp_q[t][0]) else begin
          $display("Mismatch at %0t: tile (%0d,%0d) got %h, expected %h",
                   $time, out_x_o, out_y_o, out_data_o, exp_q[t][0]);
          errors++;
        end
        void'(exp_q[t].pop_front());
      end
    end
  end

  function automatic int in_flight();
    int n = 0;
    for (int t = 0; t < tiles_c; t++)
      n += exp_q[t].size();
    return n;
  endfunction

  // drives the packet on a rising edge and holds it until accepted
  task automatic send(input int x, input int y, input logic [15:0] data);
    int n;
    in_valid_i <= 1'b1;
    in_x_i     <= x_cord_width_c'(x);
    in_y_i     <= y_cord_width_c'(y);
    in_data_i  <= data;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!in_ready_o && n < 100);
    if (!in_ready_o) begin
      $display("Timeout: input not accepted within 100 cycles at %0t", $time);
      timeouts++;
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    in_valid_i <= 1'b0;
    n = 0;
    while (in_flight() != 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (in_flight() != 0) begin
      $display("Timeout: %0d packets still missing after %0d cycles", in_flight(), limit);
      timeouts++;
    end
  endtask

  task automatic close_test(input string name, input int err0, input int to0);
    int bad;
    bad = (errors - err0) + (timeouts - to0);
    tests_run++;
    if (bad == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d problems", name, bad);
    end
  endtask

  initial begin
    int e0;
    int t0;
    int n;
    void'($urandom(32'h287213f6));
    arst_n_i    = 1'b0;
    in_valid_i  = 1'b0;
    in_x_i      = '0;
    in_y_i      = '0;
    in_data_i   = '0;
    out_ready_i = 1'b1;

    e0 = errors;
    t0 = timeouts;
    repeat (16) @(posedge clk);
    arst_n_i <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!in_ready_o && n < 4);
    if (!in_ready_o) begin
      $display("Timeout: in_ready_o still low 4 cycles after reset");
      timeouts++;
    end
    assert (!out_valid_o && !misroute_o) else begin
      $display("Mismatch at %0t: output or misroute flag high after reset", $time);
      errors++;
    end
    close_test("reset", e0, t0);

    e0 = errors;
    t0 = timeouts;
    for (int y = 0; y < num_y_c; y++) begin
      for (int x = 0; x < num_x_c; x++) begin
        send(x, y, 16'($urandom));
        wait_drain(100);
      end
    end
    close_test("delivery", e0, t0);

    e0 = errors;
    t0 = timeouts;
    repeat (n_rand_c)
      send($urandom_range(0, num_x_c - 1), $urandom_range(0, num_y_c - 1), 16'($urandom));
    wait_drain(2000);
    close_test("order", e0, t0);

    e0 = errors;
    t0 = timeouts;
    bp_en <= 1'b1;
    repeat (n_rand_c)
      send($urandom_range(0, num_x_c - 1), $urandom_range(0, num_y_c - 1), 16'($urandom));
    wait_drain(4000);
    bp_en <= 1'b0;
    close_test("backpressure", e0, t0);

    e0 = errors;
    t0 = timeouts;
    send(3, $urandom_range(0, num_y_c - 1), 16'hdead); // leaves through the east edge
    in_valid_i <= 1'b0;
    n = 0;
    while (!misroute_o && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (!misroute_o) begin
      $display("Timeout: misroute_o not raised within 50 cycles");
      timeouts++;
    end
    // normal traffic still flows and the dropped packet never shows up
    repeat (8)
      send($urandom_range(0, num_x_c - 1), $urandom_range(0, num_y_c - 1), 16'($urandom));
    wait_drain(200);
    close_test("misroute", e0, t0);

    repeat (5) @(posedge clk);
    $display("tests run %0d, failed %0d, errors %0d, timeouts %0d",
             tests_run, tests_failed, errors, timeouts);
    if (tests_failed == 0 && errors == 0 && timeouts == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== noc_top.sv ====
`timescale 1ns/100ps
// ********************
// mesh NoC top, num_x_p <= 4 and num_y_p <= 2
// packets enter at tile (0,0) only
// an X or Y outside the grid raises misroute_o, packet is dropped
// ********************

module noc_top
  import noc_pkg::*;
#(
  parameter int num_x_p      = 3,
  parameter int num_y_p      = 2,
  parameter int data_width_p = 16
) (
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic [x_cord_width_c-1:0] in_x_i,
  input  logic [y_cord_width_c-1:0] in_y_i,
  input  logic [data_width_p-1:0]   in_data_i,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic [x_cord_width_c-1:0] out_x_o,
  output logic [y_cord_width_c-1:0] out_y_o,
  output logic [data_width_p-1:0]   out_data_o,
  output logic                      misroute_o
);

  noc_link_if #(.data_width_p(data_width_p)) inj_link ();
  noc_link_if #(.data_width_p(data_width_p)) ej_link [num_x_p*num_y_p] ();

  noc_inject #(
    .data_width_p(data_width_p)
  ) inject (
    .clk(clk)
    ,.arst_n_i(arst_n_i)
    ,.in_valid_i(in_valid_i)
    ,.in_ready_o(in_ready_o)
    ,.in_x_i(in_x_i)
    ,.in_y_i(in_y_i)
    ,.in_data_i(in_data_i)
    ,.link(inj_link)
  );

  noc_mesh #(
    .num_x_p(num_x_p)
    ,.num_y_p(num_y_p)
    ,.data_width_p(data_width_p)
  ) mesh (
    .clk(clk)
    ,.arst_n_i(arst_n_i)
    ,.inj(inj_link)
    ,.ej(ej_link)
    ,.misroute_o(misroute_o)
  );

  noc_eject #(
    .num_x_p(num_x_p)
    ,.num_y_p(num_y_p)
    ,.data_width_p(data_width_p)
  ) eject (
    .clk(clk)
    ,.arst_n_i(arst_n_i)
    ,.tile_link(ej_link)
    ,.out_valid_o(out_valid_o)
    ,.out_ready_i(out_ready_i)
    ,.out_x_o(out_x_o)
    ,.out_y_o(out_y_o)
    ,.out_data_o(out_data_o)
  );

endmodule

// ==== noc_eject.sv ====
`timescale 1ns/100ps
// ********************
// merges all local router outputs onto one port
// out_x_o/out_y_o name the tile the packet came out of
// ********************

module noc_eject
  import noc_pkg::*;
#(
  parameter int num_x_p      = 3,
  parameter int num_y_p      = 2,
  parameter int data_width_p = 16
) (
  input  logic                      clk,
  input  logic                      arst_n_i,
  noc_link_if.receiver              tile_link [num_x_p*num_y_p],
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic [x_cord_width_c-1:0] out_x_o,
  output logic [y_cord_width_c-1:0] out_y_o,
  output logic [data_width_p-1:0]   out_data_o
);

  localparam int tiles_lp = num_x_p * num_y_p;
  localparam int iw_lp    = (tiles_lp > 1) ? $clog2(tiles_lp) : 1;

  logic [tiles_lp-1:0]     v;
  logic [tiles_lp-1:0]     take;
  logic [data_width_p-1:0] d [tiles_lp];
  logic [iw_lp-1:0]        pick;
  logic [iw_lp-1:0]        last_q;
  logic                    hit;
  logic                    load;

  for (genvar t = 0; t < tiles_lp; t++) begin : tile_g
    assign v[t]               = tile_link[t].valid;
    assign d[t]               = tile_link[t].data;
    assign tile_link[t].ready = take[t];
  end

  assign load = !out_valid_o || out_ready_i;

  always_comb begin
    int idx;
    hit  = 1'b0;
    pick = '0;
    take = '0;
    for (int k = 1; k <= tiles_lp; k++) begin
      idx = (int'(last_q) + k) % tiles_lp; // rotate past last winner
      if (!hit && v[idx]) begin
        hit  = 1'b1;
        pick = iw_lp'(idx);
      end
    end
    if (hit && load)
      take[pick] = 1'b1;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_o <= 1'b0;
      last_q      <= '0;
    end else if (load) begin
      out_valid_o <= hit;
      if (hit)
        last_q <= pick;
    end
  end

  // tile index back to grid coordinates
  always_ff @(posedge clk) begin
    if (load && hit) begin
      out_x_o    <= x_cord_width_c'(int'(pick) % num_x_p);
      out_y_o    <= y_cord_width_c'(int'(pick) / num_x_p);
      out_data_o <= d[pick];
    end
  end

endmodule

// ==== noc_inject.sv ====
`timescale 1ns/100ps
// ********************
// one-entry input register into tile (0,0)
// packet shows on the link one cycle after in_valid_i/in_ready_o
// ********************

module noc_inject
  import noc_pkg::*;
#(
  parameter int data_width_p = 16
) (
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic [x_cord_width_c-1:0] in_x_i,
  input  logic [y_cord_width_c-1:0] in_y_i,
  input  logic [data_width_p-1:0]   in_data_i,
  noc_link_if.sender                link
);

  logic                      full_q;
  logic [x_cord_width_c-1:0] x_q;
  logic [y_cord_width_c-1:0] y_q;
  logic [data_width_p-1:0]   data_q;

  assign in_ready_o = !full_q || link.ready; // empty or draining this edge

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i)
      full_q <= 1'b0;
    else if (in_valid_i && in_ready_o)
      full_q <= 1'b1;
    else if (link.ready)
      full_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      x_q    <= in_x_i;
      y_q    <= in_y_i;
      data_q <= in_data_i;
    end
  end

  assign link.valid = full_q;
  assign link.dst_x = x_q;
  assign link.dst_y = y_q;
  assign link.data  = data_q;

endmodule

// ==== noc_mesh.sv ====
`timescale 1ns/100ps
// ********************
// grid of routers, tile index is y * num_x_p + x
// only tile (0,0) takes injected packets
// outward edge links end in tie-offs
// ********************

module noc_mesh
  import noc_pkg::*;
#(
  parameter int num_x_p      = 3,
  parameter int num_y_p      = 2,
  parameter int data_width_p = 16
) (
  input  logic         clk,
  input  logic         arst_n_i,
  noc_link_if.receiver inj,
  noc_link_if.sender   ej [num_x_p*num_y_p],
  output logic         misroute_o
);

  localparam int tiles_lp = num_x_p * num_y_p;

  // router outputs toward neighbours, as [tile][dir]
  logic [tiles_lp-1:0][4:0]  ov;
  logic [tiles_lp-1:0][4:0]  ordy;
  logic [tiles_lp-1:0][4:0]  mis;
  logic [x_cord_width_c-1:0] ox [tiles_lp][5];
  logic [y_cord_width_c-1:0] oy [tiles_lp][5];
  logic [data_width_p-1:0]   od [tiles_lp][5];

  for (genvar y = 0; y < num_y_p; y++) begin : row_g
    for (genvar x = 0; x < num_x_p; x++) begin : col_g
      localparam int t_lp = y * num_x_p + x;

      noc_link_if #(.data_width_p(data_width_p)) rin  [5] ();
      noc_link_if #(.data_width_p(data_width_p)) rout [5] ();

      noc_router #(
        .my_x_p(x)
        ,.my_y_p(y)
        ,.data_width_p(data_width_p)
      ) router (
        .clk(clk)
        ,.arst_n_i(arst_n_i)
        ,.link_in(rin)
        ,.link_out(rout)
      );

      if (t_lp == 0) begin : inj_g
        assign rin[P].valid = inj.valid;
        assign rin[P].dst_x = inj.dst_x;
        assign rin[P].dst_y = inj.dst_y;
        assign rin[P].data  = inj.data;
        assign inj.ready    = rin[P].ready;
      end else begin : idle_g
        assign rin[P].valid = 1'b0;
        assign rin[P].dst_x = '0;
        assign rin[P].dst_y = '0;
        assign rin[P].data  = '0;
      end

      assign ej[t_lp].valid = rout[P].valid;
      assign ej[t_lp].dst_x = rout[P].dst_x;
      assign ej[t_lp].dst_y = rout[P].dst_y;
      assign ej[t_lp].data  = rout[P].data;
      assign rout[P].ready  = ej[t_lp].ready;
      assign mis[t_lp][P]   = 1'b0;

      for (genvar d = 1; d < 5; d++) begin : dir_g // W, E, N, S
        localparam bit edge_lp = (d == W && x == 0) || (d == E && x == num_x_p - 1)
                              || (d == N && y == 0) || (d == S && y == num_y_p - 1);
        localparam int nb_lp  = (d == W) ? t_lp - 1 : (d == E) ? t_lp + 1
                              : (d == N) ? t_lp - num_x_p : t_lp + num_x_p;
        localparam int opp_lp = (d == W) ? E : (d == E) ? W : (d == N) ? S : N;

        if (edge_lp) begin : edge_g
          noc_link_tieoff tieoff (
            .clk(clk)
            ,.arst_n_i(arst_n_i)
            ,.link_in(rout[d])
            ,.link_out(rin[d])
            ,.misroute_o(mis[t_lp][d])
          );
        end else begin : link_g
          assign ov[t_lp][d]   = rout[d].valid;
          assign ox[t_lp][d]   = rout[d].dst_x;
          assign oy[t_lp][d]   = rout[d].dst_y;
          assign od[t_lp][d]   = rout[d].data;
          assign rout[d].ready = ordy[t_lp][d];
          // pull from the facing output of the neighbour
          assign rin[d].valid  = ov[nb_lp][opp_lp];
          assign rin[d].dst_x  = ox[nb_lp][opp_lp];
          assign rin[d].dst_y  = oy[nb_lp][opp_lp];
          assign rin[d].data   = od[nb_lp][opp_lp];
          assign ordy[nb_lp][opp_lp] = rin[d].ready;
          assign mis[t_lp][d]  = 1'b0;
        end
      end
    end
  end

  assign misroute_o = |mis;

endmodule

// ==== noc_link_tieoff.sv ====
`timescale 1ns/100ps
// ********************
// sink for a mesh-edge link
// anything arriving here had a destination outside the grid
// ********************

module noc_link_tieoff (
  input  logic         clk,
  input  logic         arst_n_i,
  noc_link_if.receiver link_in,
  noc_link_if.sender   link_out,
  output logic         misroute_o
);

  assign link_in.ready  = 1'b1; // swallow everything
  assign link_out.valid = 1'b0;
  assign link_out.dst_x = '0;
  assign link_out.dst_y = '0;
  assign link_out.data  = '0;

  // sticky until reset
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i)
      misroute_o <= 1'b0;
    else if (link_in.valid)
      misroute_o <= 1'b1;
  end

endmodule

// ==== noc_router.sv ====
`timescale 1ns/100ps
// ********************
// five-port router, X first then Y
// each output is registered, so one hop costs a cycle at least
// round-robin per output, starting after the last winner
// ********************

module noc_router
  import noc_pkg::*;
#(
  parameter int my_x_p       = 0,
  parameter int my_y_p       = 0,
  parameter int data_width_p = 16
) (
  input logic          clk,
  input logic          arst_n_i,
  noc_link_if.receiver link_in  [5],
  noc_link_if.sender   link_out [5]
);

  localparam logic [x_cord_width_c-1:0] my_x_lp = x_cord_width_c'(my_x_p);
  localparam logic [y_cord_width_c-1:0] my_y_lp = y_cord_width_c'(my_y_p);

  noc_link_if #(.data_width_p(data_width_p)) head [5] ();

  logic [4:0]                in_v;
  logic [4:0]                take;
  logic [x_cord_width_c-1:0] in_x [5];
  logic [y_cord_width_c-1:0] in_y [5];
  logic [data_width_p-1:0]   in_d [5];
  noc_dir_e                  route [5];

  logic [4:0]                out_v;
  logic [4:0]                out_rdy;
  logic [4:0]                load;
  logic [4:0]                hit;
  logic [2:0]                pick [5];
  logic [2:0]                last_q [5]; // previous winner per output
  logic [x_cord_width_c-1:0] out_x [5];
  logic [y_cord_width_c-1:0] out_y [5];
  logic [data_width_p-1:0]   out_d [5];

  for (genvar i = 0; i < 5; i++) begin : port_g
    noc_fifo #(
      .data_width_p(data_width_p)
    ) fifo (
      .clk(clk)
      ,.arst_n_i(arst_n_i)
      ,.enq(link_in[i])
      ,.deq(head[i])
    );

    assign in_v[i]        = head[i].valid;
    assign in_x[i]        = head[i].dst_x;
    assign in_y[i]        = head[i].dst_y;
    assign in_d[i]        = head[i].data;
    assign head[i].ready  = take[i];

    assign link_out[i].valid = out_v[i];
    assign link_out[i].dst_x = out_x[i];
    assign link_out[i].dst_y = out_y[i];
    assign link_out[i].data  = out_d[i];
    assign out_rdy[i]        = link_out[i].ready;
    assign load[i]           = !out_v[i] || out_rdy[i]; // register free next edge
  end

  // dimension order, X settles first
  always_comb begin
    for (int i = 0; i < 5; i++) begin
      if (in_x[i] > my_x_lp)
        route[i] = E;
      else if (in_x[i] < my_x_lp)
        route[i] = W;
      else if (in_y[i] > my_y_lp)
        route[i] = S;
      else if (in_y[i] < my_y_lp)
        route[i] = N;
      else
        route[i] = P;
    end
  end

  always_comb begin
    int idx;
    take = '0;
    for (int o = 0; o < 5; o++) begin
      hit[o]  = 1'b0;
      pick[o] = '0;
      for (int k = 1; k <= 5; k++) begin
        idx = (int'(last_q[o]) + k) % 5;
        if (!hit[o] && in_v[idx] && route[idx] == noc_dir_e'(o)) begin
          hit[o]  = 1'b1;
          pick[o] = 3'(idx);
        end
      end
      if (hit[o] && load[o])
        take[pick[o]] = 1'b1; // one output per input, no overlap
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_v <= '0;
      for (int o = 0; o < 5; o++)
        last_q[o] <= '0;
    end else begin
      for (int o = 0; o < 5; o++) begin
        if (load[o])
          out_v[o] <= hit[o];
        if (load[o] && hit[o])
          last_q[o] <= pick[o];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < 5; o++) begin
      if (load[o] && hit[o]) begin
        out_x[o] <= in_x[pick[o]];
        out_y[o] <= in_y[pick[o]];
        out_d[o] <= in_d[pick[o]];
      end
    end
  end

endmodule

// ==== noc_fifo.sv ====
`timescale 1ns/100ps
// ********************
// two-entry link buffer
// enq ready comes from the count only, so no ready path crosses it
// ********************

module noc_fifo
  import noc_pkg::*;
#(
  parameter int data_width_p = 16
) (
  input logic          clk,
  input logic          arst_n_i,
  noc_link_if.receiver enq,
  noc_link_if.sender   deq
);

  localparam int w_lp = x_cord_width_c + y_cord_width_c + data_width_p;

  logic [w_lp-1:0] mem [2];
  logic [1:0]      cnt_q;
  logic            wr_q;
  logic            rd_q;
  logic            push;
  logic            pop;

  assign enq.ready = (cnt_q != 2'd2);
  assign deq.valid = (cnt_q != 2'd0);
  assign {deq.dst_x, deq.dst_y, deq.data} = mem[rd_q];

  assign push = enq.valid && enq.ready;
  assign pop  = deq.valid && deq.ready;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
      wr_q  <= 1'b0;
      rd_q  <= 1'b0;
    end else begin
      cnt_q <= cnt_q + 2'(push) - 2'(pop);
      if (push)
        wr_q <= !wr_q;
      if (pop)
        rd_q <= !rd_q;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_q] <= {enq.dst_x, enq.dst_y, enq.data};
  end

endmodule

// ==== noc_link_if.sv ====
`timescale 1ns/100ps
// ********************
// one-packet valid/ready link
// sender holds its packet until ready is seen
// ********************

interface noc_link_if
  import noc_pkg::*;
#(
  parameter int data_width_p = 16
) ();

  logic                      valid;
  logic                      ready;
  logic [x_cord_width_c-1:0] dst_x; // destination tile
  logic [y_cord_width_c-1:0] dst_y;
  logic [data_width_p-1:0]   data;

  modport sender (output valid, output dst_x, output dst_y, output data, input ready);
  modport receiver (input valid, input dst_x, input dst_y, input data, output ready);

endinterface

// ==== noc_pkg.sv ====
// ********************
// mesh coordinate widths, sized for at most 4 x 2 tiles
// port order of every router is P, W, E, N, S
// ********************

package noc_pkg;

  localparam int x_cord_width_c = 2; // up to 4 columns
  localparam int y_cord_width_c = 1; // up to 2 rows

  // router port index, y grows toward S
  typedef enum logic [2:0] {
    P = 3'd0, // local tile
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } noc_dir_e;

endpackage
